//--- hdl/trigTable.mem
// Line bin*8+pos, 5 hex digits: signed 10-bit sine in bits 19:10, signed 10-bit cosine in 9:0
001ff
5a569
7fc00
5a697
00201
a5e97
80400
a5d69
001ff
7fc00
00201
80400
001ff
7fc00
00201
80400
001ff
5a697
80400
5a569
00201
a5d69
7fc00
a5e97
001ff
00201
001ff
00201
001ff
00201
001ff
00201

//--- vlog.f
hdl/cqtPkg.sv
hdl/trigRom.sv
hdl/opSequencer.sv
hdl/octaveScheduler.sv
hdl/sampleWindow.sv
hdl/octaveBank.sv
hdl/cqtTop.sv
tests/cqtTb.sv

//--- Makefile
TOP = cqtTb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -o cqtSim
	./obj_dir/cqtSim | tee sim.log
	grep -q "^ALL CHECKS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tests/cqtTb.sv
/* Table-driven testbench for cqtTop with a behavioural model of the sliding DFT.
   Reads hdl/trigTable.mem relative to the project root, so run from there. */
module cqtTb
    import cqtPkg::*;
();

    localparam int FixedRows = 21;
    localparam int RandomRows = 32;
    localparam int TotalRows = FixedRows + RandomRows;
    localparam int Latency = 26;    // Accepting edge to the edge that samples done

    typedef struct {
        int value;
        int gap;    // Idle cycles before the sample is offered
        bit poke;   // Keeps sampleReady high into the busy phase
    } stimRow;

    logic clk;
    logic rst;
    logic sampleReady;
    logic signed [SampleWidth-1:0] sample;
    logic ready;
    logic done;
    magWord magnitudes [TotalBins];

    stimRow rows [FixedRows];
    logic [2*TrigWidth-1:0] trigMem [BinsPerOctave*TrigPositions];
    int seed = 32'hf092;
    int cycleCount = 0;
    int cycleLimit = 0;
    int doneCount = 0;

    // Reference model state
    longint win [OctaveCount][TopWindow];
    longint sinAcc [OctaveCount][BinsPerOctave];
    longint cosAcc [OctaveCount][BinsPerOctave];
    longint expMag [TotalBins];
    int posCount [OctaveCount];
    int stepCount = 0;

    cqtTop uut (.clk, .rst, .sampleReady, .sample, .ready, .done, .magnitudes);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (!rst && done)
            doneCount <= doneCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit)
        begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            abortRun();
        end
    end

    task automatic abortRun();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic checkSignal(string name, logic got, logic expected);
        assert (got === expected)
        else
        begin
            $display("error: %s got %h expected %h", name, got, expected);
            abortRun();
        end
    endtask

    task automatic checkMagnitudes();
        for (int i = 0; i < TotalBins; i++)
        begin
            assert (magnitudes[i] == magWord'(expMag[i]))
            else
            begin
                $display("error: magnitudes[%0d] got %h expected %h", i, magnitudes[i],
                         magWord'(expMag[i]));
                abortRun();
            end
        end
    endtask

    // Sine sits in the upper half of a table line, cosine in the lower
    function automatic longint trigHalf(int b, int p, bit upper);
        logic [2*TrigWidth-1:0] line;
        logic signed [TrigWidth-1:0] half;
        line = trigMem[b*TrigPositions+p];
        half = upper ? line[2*TrigWidth-1:TrigWidth] : line[TrigWidth-1:0];
        return longint'(half);
    endfunction

    function automatic longint approxMag(longint s, longint c);
        longint a;
        longint b;
        a = (s < 0) ? -s : s;
        b = (c < 0) ? -c : c;
        return (a > b) ? a + b / 2 : b + a / 2;     // Larger plus half the smaller
    endfunction

    task automatic modelStep(int value);
        longint inVal [OctaveCount];
        longint s;
        longint c;
        int depth;
        int p;
        int idx;
        inVal[0] = value;
        for (int o = 1; o < OctaveCount; o++)
            inVal[o] = win[o-1][0] + win[o-1][1];   // Pair above, before this step's shift
        for (int o = 0; o < OctaveCount; o++)
        begin
            if (stepCount % (1 << o) == 0)
            begin
                depth = TopWindow >> o;
                for (int i = depth - 1; i > 0; i--)
                    win[o][i] = win[o][i-1];
                win[o][0] = inVal[o];
                p = posCount[o] % TrigPositions;
                for (int b = 0; b < BinsPerOctave; b++)
                begin
                    s = trigHalf(b, p, 1'b1);
                    c = trigHalf(b, p, 1'b0);
                    idx = (OctaveCount - 1 - o) * BinsPerOctave + b;
                    sinAcc[o][b] -= win[o][depth-1] * s;
                    cosAcc[o][b] -= win[o][depth-1] * c;
                    expMag[idx] = approxMag(sinAcc[o][b], cosAcc[o][b]);
                    sinAcc[o][b] += win[o][0] * s;
                    cosAcc[o][b] += win[o][0] * c;
                end
                posCount[o]++;
            end
        end
        stepCount++;
    endtask

    task automatic runRow(int value, int gap, bit poke);
        repeat (gap) @(posedge clk);
        @(posedge clk);
        sample <= SampleWidth'(value);
        sampleReady <= 1'b1;
        @(posedge clk);                 // Accepting edge
        sampleReady <= poke;
        modelStep(value);
        for (int j = 0; j <= Latency; j++)
        begin
            if (j > 0)
                @(posedge clk);
            if (j == Latency / 2)
                sampleReady <= 1'b0;
            @(negedge clk);
            checkSignal("ready", ready, j == Latency);
            checkSignal("done", done, j == Latency - 1);
            if (j == Latency - 1)
                checkMagnitudes();
        end
    endtask

    initial
    begin
        int maxGap;
        logic signed [SampleWidth-1:0] randSample;
        rst = 1'b1;
        sampleReady = 1'b0;
        sample = '0;
        $readmemh("hdl/trigTable.mem", trigMem);
        win = '{default: 0};
        sinAcc = '{default: 0};
        cosAcc = '{default: 0};
        expMag = '{default: 0};
        posCount = '{default: 0};
        // Four lead samples, an impulse at sample 4, then sixteen zeros
        rows = '{'{100, 0, 1'b0}, '{-2048, 2, 1'b1}, '{2047, 0, 1'b0}, '{-1, 5, 1'b1},
                 '{2047, 1, 1'b0}, '{0, 0, 1'b0}, '{0, 3, 1'b1}, '{0, 0, 1'b0},
                 '{0, 1, 1'b0}, '{0, 0, 1'b1}, '{0, 4, 1'b0}, '{0, 0, 1'b0},
                 '{0, 2, 1'b1}, '{0, 0, 1'b0}, '{0, 0, 1'b0}, '{0, 5, 1'b0},
                 '{0, 1, 1'b1}, '{0, 0, 1'b0}, '{0, 3, 1'b0}, '{0, 0, 1'b1}, '{0, 0, 1'b0}};
        maxGap = 0;
        foreach (rows[i])
            maxGap = (rows[i].gap > maxGap) ? rows[i].gap : maxGap;
        cycleLimit = TotalRows * (28 + maxGap) + 100;   // Gap, drive cycle, 27 to ready
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkSignal("ready", ready, 1'b1);
        checkSignal("done", done, 1'b0);
        checkMagnitudes();
        foreach (rows[i])
            runRow(rows[i].value, rows[i].gap, rows[i].poke);
        for (int i = 0; i < RandomRows; i++)
        begin
            randSample = SampleWidth'($random(seed));
            runRow(randSample, i % 3, (i % 5) == 0);
        end
        assert (doneCount == TotalRows)
        begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
        else
        begin
            $display("error: doneCount got %h expected %h", doneCount, TotalRows);
            abortRun();
        end
    end

endmodule

//--- hdl/cqtTop.sv
/* Multi-octave sliding DFT top. One sample per ready/sampleReady handshake, 26 cycles to done.
   magnitudes holds the lowest octave first, BinsPerOctave entries per octave. */
module cqtTop
    import cqtPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic sampleReady,
    input  logic signed [SampleWidth-1:0] sample,
    output logic ready,
    output logic done,
    output magWord magnitudes [TotalBins]
);

    octaveIndex octave;
    binIndex bin;
    logic addPass;
    logic writeSample;
    logic passActive;
    logic [OctaveCount-1:0] octaveEnable;
    tablePos posByOctave [OctaveCount];
    trigWord sinWord;
    trigWord cosWord;

    opSequencer sequencer (.clk, .rst, .sampleReady, .ready, .writeSample, .addPass,
                           .done, .octave, .bin);

    octaveScheduler scheduler (.clk, .rst, .advance(done), .octaveEnable);

    // Only the active octave addresses the ROM
    trigRom rom (.bin, .pos(posByOctave[octave]), .sinWord, .cosWord);

    // Octave index sits at 0 while idle, so banks are held off outside the passes
    assign passActive = !(ready || writeSample || done);

    for (genvar o = 0; o < OctaveCount; o++)
    begin : gOctave
        typedef logic signed [SampleWidth+o-1:0] octSample;
        localparam int Depth = TopWindow >> o;
        localparam int Base = (OctaveCount - 1 - o) * BinsPerOctave;

        octSample windowIn, newest, second, oldest;
        logic signed [SampleWidth+o:0] decimated;   // Unread below the last octave
        logic bankEnable;
        logic windowWrite;

        if (o == 0)
        begin : gFirst
            assign windowIn = sample;
        end
        else
        begin : gChain
            assign windowIn = gOctave[o-1].decimated;
        end

        assign bankEnable = octaveEnable[o] && (octave == octaveIndex'(o)) && passActive;
        assign windowWrite = octaveEnable[o] && writeSample;

        sampleWindow #(.sampleType(octSample), .depth(Depth)) window (
            .clk, .rst, .write(windowWrite), .newSample(windowIn), .newest, .second, .oldest);

        octaveBank #(.sampleType(octSample), .depth(Depth)) bank (
            .clk, .rst, .enable(bankEnable), .addPass, .bin, .sinWord, .cosWord,
            .newest, .second, .oldest, .tablePos(posByOctave[o]), .decimated,
            .magnitude(magnitudes[Base:Base+BinsPerOctave-1]));

        // Sums must never see the window move under them
        assert property (@(posedge clk) disable iff (rst) !(bankEnable && windowWrite));
    end

endmodule

//--- hdl/octaveBank.sv
/* Running sine and cosine sums and magnitudes for the bins of one octave.
   One bin per enabled cycle; magnitude is registered in the add pass from the post-subtract sums. */
module octaveBank
    import cqtPkg::*;
#(
    parameter type sampleType = logic signed [SampleWidth-1:0],
    parameter int depth = TopWindow
)
(
    input  logic clk,
    input  logic rst,
    input  logic enable,
    input  logic addPass,
    input  binIndex bin,
    input  trigWord sinWord,
    input  trigWord cosWord,
    input  sampleType newest,
    input  sampleType second,
    input  sampleType oldest,
    output cqtPkg::tablePos tablePos,
    output logic signed [$bits(sampleType):0] decimated,
    output magWord magnitude [BinsPerOctave]
);

    // Headroom for a window of products plus residue left by unmatched table positions
    localparam int SumWidth = $bits(sampleType) + TrigWidth + $clog2(depth) + 4;

    typedef logic signed [SumWidth-1:0] sumWord;

    cqtPkg::tablePos addPos [BinsPerOctave];
    cqtPkg::tablePos subPos [BinsPerOctave];
    sumWord sinSum [BinsPerOctave];
    sumWord cosSum [BinsPerOctave];
    sampleType operand;
    sumWord sinProd;
    sumWord cosProd;
    logic [SumWidth-1:0] absSin;
    logic [SumWidth-1:0] absCos;
    magWord magNext;

    function automatic cqtPkg::tablePos nextPos(cqtPkg::tablePos pos);
        return (pos == cqtPkg::tablePos'(TrigPositions - 1)) ? '0 : pos + 1'b1;
    endfunction

    assign tablePos = addPass ? addPos[bin] : subPos[bin];

    always_comb
    begin
        operand = addPass ? newest : oldest;    // Entering or leaving sample
        sinProd = sumWord'(operand) * sumWord'(sinWord);
        cosProd = sumWord'(operand) * sumWord'(cosWord);
        absSin = sinSum[bin][SumWidth-1] ? -sinSum[bin] : sinSum[bin];
        absCos = cosSum[bin][SumWidth-1] ? -cosSum[bin] : cosSum[bin];
        // Max plus half of min
        if (absSin > absCos)
            magNext = MagWidth'(absSin) + MagWidth'(absCos >> 1);
        else
            magNext = MagWidth'(absCos) + MagWidth'(absSin >> 1);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            addPos <= '{default: '0};
            subPos <= '{default: '0};
            sinSum <= '{default: '0};
            cosSum <= '{default: '0};
            magnitude <= '{default: '0};
        end
        else if (enable && addPass)
        begin
            sinSum[bin] <= sinSum[bin] + sinProd;
            cosSum[bin] <= cosSum[bin] + cosProd;
            magnitude[bin] <= magNext;
            addPos[bin] <= nextPos(addPos[bin]);
        end
        else if (enable)
        begin
            sinSum[bin] <= sinSum[bin] - sinProd;
            cosSum[bin] <= cosSum[bin] - cosProd;
            subPos[bin] <= nextPos(subPos[bin]);
        end
    end

    // Pair of newest samples feeds the octave below
    assign decimated = newest + second;

endmodule

//--- hdl/sampleWindow.sv
/* Shift-register window of one octave, depth samples long.
   Tap 0 is the newest sample; the oldest tap is still inside the window. */
module sampleWindow
    import cqtPkg::*;
#(
    parameter type sampleType = logic signed [SampleWidth-1:0],
    parameter int depth = TopWindow
)
(
    input  logic clk,
    input  logic rst,
    input  logic write,
    input  sampleType newSample,
    output sampleType newest,
    output sampleType second,
    output sampleType oldest
);

    sampleType taps [depth];

    always_ff @(posedge clk)
    begin
        if (rst)
            taps <= '{default: '0};
        else if (write)
        begin
            taps[0] <= newSample;
            for (int i = 1; i < depth; i++)
                taps[i] <= taps[i-1];
        end
    end

    assign newest = taps[0];
    assign second = taps[1];
    assign oldest = taps[depth-1];

endmodule

//--- hdl/octaveScheduler.sv
/* Octave enables for the current sample, stepped on each done pulse.
   Octave o >= 1 runs when the sample count since reset is a multiple of 2**o. */
module octaveScheduler
    import cqtPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic advance,
    output logic [OctaveCount-1:0] octaveEnable
);

    logic [OctaveCount-2:0] prevCount;
    logic [OctaveCount-2:0] curCount;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            prevCount <= '1;    // Stands for sample -1, so sample 0 enables all
            curCount <= '0;
        end
        else if (advance)
        begin
            prevCount <= curCount;
            curCount <= curCount + 1'b1;
        end
    end

    // A bit that falls from 1 to 0 marks a carry through it
    assign octaveEnable[0] = 1'b1;
    assign octaveEnable[OctaveCount-1:1] = prevCount & ~curCount;

    // Top octave always runs, and a lower octave only runs with the one above it
    assert property (@(posedge clk) disable iff (rst)
        octaveEnable[0] && ((octaveEnable >> 1) & ~octaveEnable) == '0);

endmodule

//--- hdl/opSequencer.sv
/* Per-sample control FSM. A sample is taken when ready and sampleReady are both high;
   one write cycle, then a subtract and an add pass over all bins of each octave. */
module opSequencer
    import cqtPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic sampleReady,
    output logic ready,
    output logic writeSample,
    output logic addPass,
    output logic done,
    output octaveIndex octave,
    output binIndex bin
);

    typedef enum logic [2:0] {waitState, writeState, subState, addState, doneState} seqState;

    seqState state;
    seqState nextState;
    logic lastBin;
    logic lastOctave;

    assign lastBin = (bin == binIndex'(BinsPerOctave - 1));
    assign lastOctave = (octave == octaveIndex'(OctaveCount - 1));

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= waitState;
        else
            state <= nextState;
    end

    always_comb
    begin
        nextState = state;
        case (state)
            waitState:  if (sampleReady) nextState = writeState;
            writeState: nextState = subState;
            subState:   if (lastBin) nextState = addState;
            addState:   if (lastBin) nextState = lastOctave ? doneState : subState;
            doneState:  nextState = waitState;
            default:    nextState = waitState;
        endcase
    end

    assign ready = (state == waitState);
    assign writeSample = (state == writeState);
    assign addPass = (state == addState);
    assign done = (state == doneState);

    // Bin walks every pass, octave steps after its add pass
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            octave <= '0;
            bin <= '0;
        end
        else if (state == subState || state == addState)
        begin
            bin <= lastBin ? '0 : bin + 1'b1;
            if (state == addState && lastBin)
                octave <= lastOctave ? '0 : octave + 1'b1;  // Back to 0 for the next sample
        end
    end

    // Bin and octave wrap back to zero by the time the FSM idles
    assert property (@(posedge clk) disable iff (rst) ready |-> (bin == '0 && octave == '0));

    // Write strobe is a single-cycle event per sample
    assert property (@(posedge clk) disable iff (rst) writeSample |=> !writeSample);

endmodule

//--- hdl/trigRom.sv
/* Combinational sine and cosine ROM shared by all octaves.
   Loads hdl/trigTable.mem relative to the run directory, sine in the upper half of a line. */
module trigRom
    import cqtPkg::*;
(
    input  binIndex bin,
    input  tablePos pos,
    output trigWord sinWord,
    output trigWord cosWord
);

    localparam int Entries = BinsPerOctave * TrigPositions;

    logic [2*TrigWidth-1:0] romData [Entries];
    logic [2*TrigWidth-1:0] romWord;

    initial
    begin
        $readmemh("hdl/trigTable.mem", romData);
    end

    // Line number is bin * TrigPositions + pos
    assign romWord = romData[{bin, pos}];

    assign sinWord = trigWord'(romWord[2*TrigWidth-1:TrigWidth]);
    assign cosWord = trigWord'(romWord[TrigWidth-1:0]);

endmodule

//--- hdl/cqtPkg.sv
/* Sizes and shared types of the multi-octave sliding DFT.
   Octave o carries SampleWidth+o bit samples over a window of TopWindow>>o. */
package cqtPkg;

    localparam int BinsPerOctave = 4;
    localparam int OctaveCount = 3;
    localparam int SampleWidth = 12;    // Top octave input width
    localparam int TopWindow = 16;      // Halved for each lower octave
    localparam int TrigWidth = 10;
    localparam int TrigPositions = 8;   // Table entries per bin

    // Index widths
    localparam int BinWidth = $clog2(BinsPerOctave);
    localparam int OctaveWidth = $clog2(OctaveCount);
    localparam int PosWidth = $clog2(TrigPositions);

    // Covers the running sums of the lowest, widest octave
    localparam int MagWidth = 2 * SampleWidth + OctaveCount + 4;
    localparam int TotalBins = BinsPerOctave * OctaveCount;

    typedef logic signed [TrigWidth-1:0] trigWord;
    typedef logic [MagWidth-1:0] magWord;

    typedef logic [BinWidth-1:0] binIndex;
    typedef logic [OctaveWidth-1:0] octaveIndex;
    typedef logic [PosWidth-1:0] tablePos;

endpackage
